// ==== design/soc_bus_pkg.sv ====
// System bus package with the bus word width and its address and data types
package soc_bus_pkg;

	// ==============================
	// Word width
	// ==============================

	// Address and data share one word width
	localparam int BUS_WIDTH = 32;

	// ==============================
	// Vector types
	// ==============================

	// Byte address on the shared bus
	typedef logic [BUS_WIDTH-1:0] bus_addr_t;

	// Read and write data word
	typedef logic [BUS_WIDTH-1:0] bus_data_t;

endpackage

// ==== design/soc_map_pkg.sv ====
// Address map package with region codes, RAM geometry and MMIO register layout
package soc_map_pkg;

	// ==============================
	// Regions, top address nibble
	// ==============================
	typedef logic [3:0] region_t;

	localparam region_t REGION_RAM  = 4'h1;
	localparam region_t REGION_MMIO = 4'h4;

	// ==============================
	// On-chip RAM
	// ==============================
	localparam int RAM_WORDS   = 1024;
	// Accept to ready, in cycles
	localparam int RAM_LATENCY = 3;

	// Word index, address bits 11 down to 2
	typedef logic [9:0] ram_index_t;

	// ==============================
	// MMIO block
	// ==============================
	localparam int LED_WIDTH = 10;
	typedef logic [LED_WIDTH-1:0] led_t;

	// Byte offsets inside the region
	localparam int unsigned MMIO_LED_OFFSET   = 0;
	localparam int unsigned MMIO_FAULT_OFFSET = 4;

	localparam int FAULT_COUNT_WIDTH = 16;
	typedef logic [FAULT_COUNT_WIDTH-1:0] fault_count_t;

endpackage

// ==== design/soc_bus_if.sv ====
// One request/ready bus segment between a master and a slave
interface soc_bus_if;
	import soc_bus_pkg::*;

	// Request side, held steady until ready
	logic      request;
	logic      rw;
	bus_addr_t address;
	bus_data_t wdata;

	// Response side, ready is a single cycle pulse
	bus_data_t rdata;
	logic      ready;

	modport master (
		output request,
		output rw,
		output address,
		output wdata,
		input  rdata,
		input  ready
	);

	modport slave (
		input  request,
		input  rw,
		input  address,
		input  wdata,
		output rdata,
		output ready
	);

endinterface

// ==== design/bus_arbiter.sv ====
// Fixed-priority arbiter that puts one of three requesters onto the shared bus
module bus_arbiter (
	input  logic                  clock,
	input  logic                  i_rst_n,

	// Port A, instruction fetch, read only
	input  logic                  i_pa_request,
	input  soc_bus_pkg::bus_addr_t i_pa_address,
	output logic                  o_pa_ready,
	output soc_bus_pkg::bus_data_t o_pa_rdata,

	// Port B, data
	input  logic                  i_pb_request,
	input  logic                  i_pb_rw,
	input  soc_bus_pkg::bus_addr_t i_pb_address,
	input  soc_bus_pkg::bus_data_t i_pb_wdata,
	output logic                  o_pb_ready,
	output soc_bus_pkg::bus_data_t o_pb_rdata,

	// Port C, DMA
	input  logic                  i_pc_request,
	input  logic                  i_pc_rw,
	input  soc_bus_pkg::bus_addr_t i_pc_address,
	input  soc_bus_pkg::bus_data_t i_pc_wdata,
	output logic                  o_pc_ready,
	output soc_bus_pkg::bus_data_t o_pc_rdata,

	soc_bus_if.master             bus
);

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_PA,
		ARB_PB,
		ARB_PC
	} arb_state_e;

	arb_state_e state;

	// ==============================
	// Grant FSM
	// ==============================

	// Priority B, C, A; grant held until the bus answers
	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			state <= ARB_IDLE;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (i_pb_request)
						state <= ARB_PB;
					else if (i_pc_request)
						state <= ARB_PC;
					else if (i_pa_request)
						state <= ARB_PA;
				end
				default: begin
					// One idle cycle after every transfer
					if (bus.ready)
						state <= ARB_IDLE;
				end
			endcase
		end
	end

	// ==============================
	// Bus mux
	// ==============================
	always_comb begin
		bus.request = 1'b0;
		bus.rw      = 1'b0;
		bus.address = '0;
		bus.wdata   = '0;
		case (state)
			ARB_PA: begin
				bus.request = i_pa_request;
				bus.address = i_pa_address;
			end
			ARB_PB: begin
				bus.request = i_pb_request;
				bus.rw      = i_pb_rw;
				bus.address = i_pb_address;
				bus.wdata   = i_pb_wdata;
			end
			ARB_PC: begin
				bus.request = i_pc_request;
				bus.rw      = i_pc_rw;
				bus.address = i_pc_address;
				bus.wdata   = i_pc_wdata;
			end
			default: ;
		endcase
	end

	// Response only reaches the granted port
	assign o_pa_ready = (state == ARB_PA) && bus.ready;
	assign o_pb_ready = (state == ARB_PB) && bus.ready;
	assign o_pc_ready = (state == ARB_PC) && bus.ready;

	assign o_pa_rdata = (state == ARB_PA) ? bus.rdata : '0;
	assign o_pb_rdata = (state == ARB_PB) ? bus.rdata : '0;
	assign o_pc_rdata = (state == ARB_PC) ? bus.rdata : '0;

endmodule

// ==== design/bus_decoder.sv ====
// Address decoder that routes bus requests to RAM or MMIO and completes unmapped accesses
module bus_decoder (
	input  logic      clock,
	input  logic      i_rst_n,
	soc_bus_if.slave  bus,
	soc_bus_if.master ram,
	soc_bus_if.master mmio,
	output logic      o_fault
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	region_t region;
	logic    sel_ram;
	logic    sel_mmio;
	logic    unmapped_req;
	logic    fault_q;

	// ==============================
	// Region decode
	// ==============================
	assign region   = bus.address[BUS_WIDTH-1 -: $bits(region_t)];
	assign sel_ram  = (region == REGION_RAM);
	assign sel_mmio = (region == REGION_MMIO);

	assign unmapped_req = bus.request && !sel_ram && !sel_mmio;

	// Only the selected target sees the request
	assign ram.request = bus.request && sel_ram;
	assign ram.rw      = bus.rw;
	assign ram.address = bus.address;
	assign ram.wdata   = bus.wdata;

	assign mmio.request = bus.request && sel_mmio;
	assign mmio.rw      = bus.rw;
	assign mmio.address = bus.address;
	assign mmio.wdata   = bus.wdata;

	// ==============================
	// Unmapped completion
	// ==============================

	// One pulse per access, the request is still held during it
	always_ff @(posedge clock) begin
		if (!i_rst_n)
			fault_q <= 1'b0;
		else
			fault_q <= unmapped_req && !fault_q;
	end

	assign o_fault = fault_q;

	// Response mux
	always_comb begin
		if (sel_ram) begin
			bus.rdata = ram.rdata;
			bus.ready = ram.ready;
		end else if (sel_mmio) begin
			bus.rdata = mmio.rdata;
			bus.ready = mmio.ready;
		end else begin
			// Unmapped reads return zero
			bus.rdata = '0;
			bus.ready = fault_q;
		end
	end

endmodule

// ==== design/ram_latency.sv ====
// On-chip word RAM that answers each access after a fixed latency
module ram_latency (
	input  logic     clock,
	input  logic     i_rst_n,
	soc_bus_if.slave bus
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int CNT_W = $clog2(RAM_LATENCY + 1);

	bus_data_t  mem [RAM_WORDS];
	bus_data_t  rdata_q;
	ram_index_t index;
	logic [CNT_W-1:0] count;
	logic       busy;
	logic       done_wait;
	logic       accept;

	assign index  = bus.address[11:2];
	assign accept = bus.request && !busy && !done_wait;

	// ==============================
	// Latency counter
	// ==============================
	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			busy      <= 1'b0;
			done_wait <= 1'b0;
			count     <= '0;
		end else if (accept) begin
			busy  <= 1'b1;
			count <= CNT_W'(RAM_LATENCY - 1);
		end else if (busy) begin
			if (count == '0) begin
				busy      <= 1'b0;
				done_wait <= 1'b1;
			end else begin
				count <= count - 1'b1;
			end
		end else if (done_wait && !bus.request) begin
			// Requester let go, ready for the next access
			done_wait <= 1'b0;
		end
	end

	// Write and read capture both happen at acceptance
	always_ff @(posedge clock) begin
		if (accept) begin
			if (bus.rw)
				mem[index] <= bus.wdata;
			rdata_q <= mem[index];
		end
	end

	assign bus.ready = busy && (count == '0);
	assign bus.rdata = rdata_q;

endmodule

// ==== design/mmio_regs.sv ====
// MMIO block with a LED register and a saturating bus-fault counter
module mmio_regs (
	input  logic                clock,
	input  logic                i_rst_n,
	soc_bus_if.slave            bus,
	input  logic                i_fault,
	output soc_map_pkg::led_t   o_led
);
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	led_t         led_q;
	fault_count_t fault_count;
	bus_data_t    rdata_q;
	logic         ready_q;
	logic         access;
	logic         hit_led;
	logic         hit_fault;

	// New access only when no ready pulse is pending
	assign access    = bus.request && !ready_q;
	assign hit_led   = (bus.address[27:0] == 28'(MMIO_LED_OFFSET));
	assign hit_fault = (bus.address[27:0] == 28'(MMIO_FAULT_OFFSET));

	// ==============================
	// Registers
	// ==============================
	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			led_q       <= '0;
			fault_count <= '0;
			ready_q     <= 1'b0;
		end else begin
			ready_q <= access;
			if (access && bus.rw && hit_led)
				led_q <= bus.wdata[LED_WIDTH-1:0];
			// Saturate at all ones
			if (i_fault && (fault_count != '1))
				fault_count <= fault_count + 1'b1;
		end
	end

	// Read data, zero for unknown offsets
	always_ff @(posedge clock) begin
		if (access) begin
			if (hit_led)
				rdata_q <= bus_data_t'(led_q);
			else if (hit_fault)
				rdata_q <= bus_data_t'(fault_count);
			else
				rdata_q <= '0;
		end
	end

	assign bus.ready = ready_q;
	assign bus.rdata = rdata_q;
	assign o_led     = led_q;

endmodule

// ==== design/soc_bus_top.sv ====
// System bus top level joining arbiter, decoder, RAM and MMIO behind plain ports
module soc_bus_top (
	input  logic                   clock,
	input  logic                   i_rst_n,

	input  logic                   i_pa_request,
	input  soc_bus_pkg::bus_addr_t i_pa_address,
	output logic                   o_pa_ready,
	output soc_bus_pkg::bus_data_t o_pa_rdata,

	input  logic                   i_pb_request,
	input  logic                   i_pb_rw,
	input  soc_bus_pkg::bus_addr_t i_pb_address,
	input  soc_bus_pkg::bus_data_t i_pb_wdata,
	output logic                   o_pb_ready,
	output soc_bus_pkg::bus_data_t o_pb_rdata,

	input  logic                   i_pc_request,
	input  logic                   i_pc_rw,
	input  soc_bus_pkg::bus_addr_t i_pc_address,
	input  soc_bus_pkg::bus_data_t i_pc_wdata,
	output logic                   o_pc_ready,
	output soc_bus_pkg::bus_data_t o_pc_rdata,

	output soc_map_pkg::led_t      o_led,
	output logic                   o_bus_fault
);

	soc_bus_if main_bus ();
	soc_bus_if ram_bus ();
	soc_bus_if mmio_bus ();

	// Fault pulse feeds both the counter and the pin
	logic bus_fault;
	assign o_bus_fault = bus_fault;

	bus_arbiter arbiter0 (
		.clock        (clock),
		.i_rst_n      (i_rst_n),
		.i_pa_request (i_pa_request),
		.i_pa_address (i_pa_address),
		.o_pa_ready   (o_pa_ready),
		.o_pa_rdata   (o_pa_rdata),
		.i_pb_request (i_pb_request),
		.i_pb_rw      (i_pb_rw),
		.i_pb_address (i_pb_address),
		.i_pb_wdata   (i_pb_wdata),
		.o_pb_ready   (o_pb_ready),
		.o_pb_rdata   (o_pb_rdata),
		.i_pc_request (i_pc_request),
		.i_pc_rw      (i_pc_rw),
		.i_pc_address (i_pc_address),
		.i_pc_wdata   (i_pc_wdata),
		.o_pc_ready   (o_pc_ready),
		.o_pc_rdata   (o_pc_rdata),
		.bus          (main_bus.master)
	);

	bus_decoder decoder0 (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.bus     (main_bus.slave),
		.ram     (ram_bus.master),
		.mmio    (mmio_bus.master),
		.o_fault (bus_fault)
	);

	ram_latency ram0 (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.bus     (ram_bus.slave)
	);

	mmio_regs mmio0 (
		.clock   (clock),
		.i_rst_n (i_rst_n),
		.bus     (mmio_bus.slave),
		.i_fault (bus_fault),
		.o_led   (o_led)
	);

endmodule

// ==== verification/tb_clock_gen.sv ====
// Testbench clock source with a period of 4 time units
module tb_clock_gen (
	output logic clock
);

	localparam int HALF_PERIOD = 2;

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

endmodule

// ==== verification/tb_soc_bus.sv ====
// Testbench for the system bus, random three-port traffic checked against a reference model
module tb_soc_bus;
	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int          TIMEOUT_CYCLES = 4000;
	localparam int          CHECK_READS    = 64;
	localparam int          TRAFFIC_OPS    = 150;
	localparam logic [31:0] SEED           = 32'h3e87_4d05;
	localparam region_t     REGION_HOLE    = 4'h8;

	logic        clock;
	logic        rst_n;
	logic [2:0]  req_q;
	logic [2:0]  rw_q;
	bus_addr_t   addr_q [3];
	bus_data_t   wdata_q [3];
	logic [2:0]  ready_w;
	bus_data_t   pa_rdata;
	bus_data_t   pb_rdata;
	bus_data_t   pc_rdata;
	led_t        led;
	logic        bus_fault;

	// Reference model state
	bus_data_t   model_ram [RAM_WORDS];
	logic        model_valid [RAM_WORDS];
	led_t        model_led;
	int          model_faults = 0;

	int          seen_faults = 0;
	int          errors = 0;
	int          timeouts = 0;
	int unsigned cycle = 0;

	tb_clock_gen clock_gen0 (.clock(clock));

	soc_bus_top dut0 (
		.clock        (clock),
		.i_rst_n      (rst_n),
		.i_pa_request (req_q[0]),
		.i_pa_address (addr_q[0]),
		.o_pa_ready   (ready_w[0]),
		.o_pa_rdata   (pa_rdata),
		.i_pb_request (req_q[1]),
		.i_pb_rw      (rw_q[1]),
		.i_pb_address (addr_q[1]),
		.i_pb_wdata   (wdata_q[1]),
		.o_pb_ready   (ready_w[1]),
		.o_pb_rdata   (pb_rdata),
		.i_pc_request (req_q[2]),
		.i_pc_rw      (rw_q[2]),
		.i_pc_address (addr_q[2]),
		.i_pc_wdata   (wdata_q[2]),
		.o_pc_ready   (ready_w[2]),
		.o_pc_rdata   (pc_rdata),
		.o_led        (led),
		.o_bus_fault  (bus_fault)
	);

	// ==============================
	// Helpers
	// ==============================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic bus_addr_t ram_addr(input ram_index_t index);
		return {REGION_RAM, 16'h0000, index, 2'b00};
	endfunction

	function automatic bus_addr_t mmio_addr(input int unsigned offset);
		return {REGION_MMIO, 28'(offset)};
	endfunction

	function automatic bus_data_t port_rdata(input int port);
		case (port)
			0: return pa_rdata;
			1: return pb_rdata;
			default: return pc_rdata;
		endcase
	endfunction

	task automatic check_value(input string name, input bus_data_t expected,
			input bus_data_t actual);
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// One request/ready transfer, port 0 is A, 1 is B, 2 is C
	task automatic bus_access(input int port, input logic rw, input bus_addr_t addr,
			input bus_data_t wdata, output bus_data_t rdata, output logic fault,
			output int unsigned done_cycle);
		int   waited;
		logic got;
		@(posedge clock);
		req_q[port]   <= 1'b1;
		rw_q[port]    <= rw;
		addr_q[port]  <= addr;
		wdata_q[port] <= wdata;
		got    = 1'b0;
		waited = 0;
		while (!got && waited < TIMEOUT_CYCLES) begin
			@(negedge clock);
			got = ready_w[port];
			waited++;
		end
		rdata      = port_rdata(port);
		fault      = bus_fault;
		done_cycle = cycle;
		if (!got) begin
			timeouts++;
			$display("Timeout: port %0d saw no ready within %0d cycles", port, TIMEOUT_CYCLES);
		end
		@(posedge clock);
		req_q[port] <= 1'b0;
	endtask

	always @(posedge clock) cycle <= cycle + 1;

	// Counts fault pulses seen on the pin
	always @(negedge clock) begin
		if (bus_fault === 1'b1)
			seen_faults <= seen_faults + 1;
	end

	// ==============================
	// Port processes
	// ==============================

	// Instruction reads from quarter 0 only
	task automatic run_port_a();
		logic [31:0] state;
		ram_index_t  index;
		bus_data_t   rdata;
		logic        fault;
		int unsigned t;
		state = SEED ^ 32'h0000_000a;
		for (int i = 0; i < TRAFFIC_OPS; i++) begin
			state = xorshift32(state);
			index = {2'b00, state[7:0]};
			bus_access(0, 1'b0, ram_addr(index), '0, rdata, fault, t);
			check_value("o_pa_rdata", model_ram[index], rdata);
		end
	endtask

	// Data or DMA traffic in the port's own quarter, with some unmapped hits
	task automatic run_traffic(input int port, input logic [31:0] seed);
		logic [31:0] state;
		ram_index_t  index;
		bus_data_t   rdata;
		logic        fault;
		int unsigned t;
		string       rd_name;
		rd_name = (port == 1) ? "o_pb_rdata" : "o_pc_rdata";
		state   = seed;
		for (int i = 0; i < TRAFFIC_OPS; i++) begin
			state = xorshift32(state);
			index = {port[1:0], state[7:0]};
			repeat (state[19:17]) @(posedge clock);
			if (state[15:12] == 4'h0) begin
				bus_access(port, state[16], {REGION_HOLE, state[27:0]}, state, rdata, fault, t);
				model_faults++;
				check_value(rd_name, '0, rdata);
				check_value("o_bus_fault", bus_data_t'(1'b1), bus_data_t'(fault));
			end else if (state[16] || !model_valid[index]) begin
				bus_access(port, 1'b1, ram_addr(index), state, rdata, fault, t);
				model_ram[index]   = state;
				model_valid[index] = 1'b1;
			end else begin
				bus_access(port, 1'b0, ram_addr(index), '0, rdata, fault, t);
				check_value(rd_name, model_ram[index], rdata);
			end
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		bus_data_t   rdata;
		bus_data_t   rdata_a;
		logic        fault;
		int unsigned t_a;
		int unsigned t_b;
		ram_index_t  index;
		logic [31:0] rnd;

		rst_n = 1'b0;
		req_q = '0;
		rw_q  = '0;
		for (int p = 0; p < 3; p++) begin
			addr_q[p]  = '0;
			wdata_q[p] = '0;
		end
		for (int i = 0; i < RAM_WORDS; i++)
			model_valid[i] = 1'b0;
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;

		@(negedge clock);
		check_value("o_pa_ready", '0, bus_data_t'(ready_w[0]));
		check_value("o_pb_ready", '0, bus_data_t'(ready_w[1]));
		check_value("o_pc_ready", '0, bus_data_t'(ready_w[2]));
		check_value("o_bus_fault", '0, bus_data_t'(bus_fault));
		check_value("o_led", '0, bus_data_t'(led));

		// Port B fills quarter 0, then reads a sample back
		rnd = SEED;
		for (int i = 0; i < RAM_WORDS / 4; i++) begin
			rnd = xorshift32(rnd);
			bus_access(1, 1'b1, ram_addr(ram_index_t'(i)), rnd, rdata, fault, t_b);
			model_ram[i]   = rnd;
			model_valid[i] = 1'b1;
		end
		for (int i = 0; i < CHECK_READS; i++) begin
			rnd   = xorshift32(rnd);
			index = {2'b00, rnd[7:0]};
			bus_access(1, 1'b0, ram_addr(index), '0, rdata, fault, t_b);
			check_value("o_pb_rdata", model_ram[index], rdata);
		end

		fork
			run_port_a();
			run_traffic(1, SEED ^ 32'h0000_00b1);
			run_traffic(2, SEED ^ 32'h0000_00c2);
		join
		check_value("o_bus_fault pulse count", bus_data_t'(model_faults),
			bus_data_t'(seen_faults));

		// LED register, truncated on the pin and zero-extended on read
		rnd = xorshift32(rnd);
		bus_access(1, 1'b1, mmio_addr(MMIO_LED_OFFSET), rnd, rdata, fault, t_b);
		model_led = rnd[LED_WIDTH-1:0];
		@(negedge clock);
		check_value("o_led", bus_data_t'(model_led), bus_data_t'(led));
		bus_access(1, 1'b0, mmio_addr(MMIO_LED_OFFSET), '0, rdata, fault, t_b);
		check_value("o_pb_rdata", bus_data_t'(model_led), rdata);
		bus_access(1, 1'b0, mmio_addr(MMIO_FAULT_OFFSET), '0, rdata, fault, t_b);
		check_value("o_pb_rdata", bus_data_t'(model_faults), rdata);

		// A and B raise requests in the same cycle on an idle bus
		rnd   = xorshift32(rnd);
		index = {2'b00, rnd[7:0]};
		fork
			bus_access(0, 1'b0, ram_addr(index), '0, rdata_a, fault, t_a);
			bus_access(1, 1'b0, ram_addr(index), '0, rdata, fault, t_b);
		join
		check_value("o_pa_rdata", model_ram[index], rdata_a);
		check_value("o_pb_rdata", model_ram[index], rdata);
		check_value("o_pb_ready before o_pa_ready", bus_data_t'(1'b1), bus_data_t'(t_b < t_a));

		$display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
design/soc_bus_pkg.sv
design/soc_map_pkg.sv
design/soc_bus_if.sv
design/bus_arbiter.sv
design/bus_decoder.sv
design/ram_latency.sv
design/mmio_regs.sv
design/soc_bus_top.sv
verification/tb_clock_gen.sv
verification/tb_soc_bus.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary -Wno-fatal
TOP       ?= tb_soc_bus
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
